/* logic/amo_pkg.sv */
// Shared widths, memory depth, operation encoding and SC failure code for the AMO unit.
package amo_pkg;

    // Width of one memory word and of every operand.
    localparam int unsigned DATA_WIDTH = 64;

    // Number of words in the local word memory.
    localparam int unsigned MEM_DEPTH = 16;

    // Word address width, follows from the depth.
    localparam int unsigned ADDR_WIDTH = $clog2(MEM_DEPTH);

    // Operation codes carried by a request.
    // Plain accesses first, then the reservation pair.
    // The read-modify-write group follows.
    typedef enum logic [3:0] {
        OP_LOAD  = 4'd0,
        OP_STORE = 4'd1,
        OP_LR    = 4'd2,
        OP_SC    = 4'd3,
        OP_SWAP  = 4'd4,
        OP_ADD   = 4'd5,
        OP_AND   = 4'd6,
        OP_OR    = 4'd7,
        OP_XOR   = 4'd8,
        // Signed compares.
        OP_MAX   = 4'd9,
        // Unsigned compare.
        OP_MAXU  = 4'd10,
        OP_MIN   = 4'd11,
        OP_MINU  = 4'd12
    } amo_op_e;

    // Response word of an SC that lost its reservation.
    // A successful SC answers with zero.
    localparam logic [DATA_WIDTH-1:0] SC_FAIL_CODE = DATA_WIDTH'(1);

endpackage

/* logic/amo_alu.sv */
// Combinational AMO computing block producing the new memory word.
`timescale 1ns/100ps

module amo_alu
(
    // Old word as read from memory.
    input  wire logic [amo_pkg::DATA_WIDTH-1:0] ld_data_i,
    // Operand latched with the request.
    input  wire logic [amo_pkg::DATA_WIDTH-1:0] st_data_i,
    input  wire amo_pkg::amo_op_e               op_i,
    // Word to be written back.
    output var  logic [amo_pkg::DATA_WIDTH-1:0] result_o
);

    logic [amo_pkg::DATA_WIDTH-1:0] sum;
    logic                           ugt;
    logic                           sgt;

    // Wrap-around addition, carry out dropped.
    assign sum = ld_data_i + st_data_i;

    // Old word greater than operand, unsigned view.
    assign ugt = (ld_data_i > st_data_i);

    // Same compare with both sides as two's complement.
    assign sgt = ($signed(ld_data_i) > $signed(st_data_i));

    always_comb
    begin : amo_result_comb
        case (op_i)
            // Nothing to modify, the old word goes back unchanged.
            amo_pkg::OP_LOAD,
            amo_pkg::OP_LR:
                result_o = ld_data_i;
            // Operand replaces the old word.
            amo_pkg::OP_STORE,
            amo_pkg::OP_SC,
            amo_pkg::OP_SWAP:
                result_o = st_data_i;
            amo_pkg::OP_ADD:
                result_o = sum;
            amo_pkg::OP_AND:
                result_o = ld_data_i & st_data_i;
            amo_pkg::OP_OR:
                result_o = ld_data_i | st_data_i;
            amo_pkg::OP_XOR:
                result_o = ld_data_i ^ st_data_i;
            // Keep the larger of the two.
            amo_pkg::OP_MAX:
                result_o = sgt ? ld_data_i : st_data_i;
            amo_pkg::OP_MAXU:
                result_o = ugt ? ld_data_i : st_data_i;
            // Keep the smaller of the two.
            amo_pkg::OP_MIN:
                result_o = sgt ? st_data_i : ld_data_i;
            amo_pkg::OP_MINU:
                result_o = ugt ? st_data_i : ld_data_i;
            // Unused encodings.
            default:
                result_o = '0;
        endcase
    end

endmodule

/* logic/amo_reservation.sv */
// LR/SC reservation register with set, match and clear rules.
`timescale 1ns/100ps

module amo_reservation
(
    input  wire logic                           clk_i,
    input  wire logic                           reset_i,
    // One-cycle pulse while an operation executes.
    input  wire logic                           exec_i,
    input  wire amo_pkg::amo_op_e               op_i,
    input  wire logic [amo_pkg::ADDR_WIDTH-1:0] addr_i,
    // Reservation valid and held on this address.
    output var  logic                           sc_ok_o
);

    logic                           rsv_valid_q;
    logic [amo_pkg::ADDR_WIDTH-1:0] rsv_addr_q;
    logic                           addr_match;
    logic                           is_write_op;

    assign addr_match = (rsv_addr_q == addr_i);

    // Operations that modify memory apart from SC.
    // SC is handled on its own below.
    always_comb
    begin : write_op_comb
        case (op_i)
            amo_pkg::OP_LOAD,
            amo_pkg::OP_LR,
            amo_pkg::OP_SC:
                is_write_op = 1'b0;
            default:
                is_write_op = 1'b1;
        endcase
    end

    // Valid bit is control state and clears on reset.
    always_ff @(posedge clk_i)
    begin : rsv_valid_ff
        if (reset_i)
        begin
            rsv_valid_q <= 1'b0;
        end
        else if (exec_i)
        begin
            if (op_i == amo_pkg::OP_LR)
            begin
                rsv_valid_q <= 1'b1;
            end
            // SC drops the reservation whether it wins or not.
            else if (op_i == amo_pkg::OP_SC)
            begin
                rsv_valid_q <= 1'b0;
            end
            // A competing write to the reserved word.
            else if (is_write_op && addr_match)
            begin
                rsv_valid_q <= 1'b0;
            end
        end
    end

    // Reserved address, only meaningful while valid.
    always_ff @(posedge clk_i)
    begin : rsv_addr_ff
        if (exec_i && (op_i == amo_pkg::OP_LR))
        begin
            rsv_addr_q <= addr_i;
        end
    end

    assign sc_ok_o = rsv_valid_q && addr_match;

endmodule

/* logic/amo_word_ram.sv */
// Word memory with registered read port and one write port.
`timescale 1ns/100ps

module amo_word_ram
(
    input  wire logic                           clk_i,
    input  wire logic                           rd_en_i,
    input  wire logic                           wr_en_i,
    // Shared by the read and the write port.
    input  wire logic [amo_pkg::ADDR_WIDTH-1:0] addr_i,
    input  wire logic [amo_pkg::DATA_WIDTH-1:0] wr_data_i,
    output var  logic [amo_pkg::DATA_WIDTH-1:0] rd_data_o
);

    // Storage array, contents survive reset like an SRAM macro.
    logic [amo_pkg::DATA_WIDTH-1:0] mem_q [amo_pkg::MEM_DEPTH];

    // Write on the enable edge.
    always_ff @(posedge clk_i)
    begin : ram_write_ff
        if (wr_en_i)
        begin
            mem_q[addr_i] <= wr_data_i;
        end
    end

    // Read data lands one cycle after the enable.
    // Output keeps its value while no read is issued.
    always_ff @(posedge clk_i)
    begin : ram_read_ff
        if (rd_en_i)
        begin
            rd_data_o <= mem_q[addr_i];
        end
    end

endmodule

/* logic/amo_sequencer.sv */
// Request handshake and read-compute-write FSM of the AMO unit.
`timescale 1ns/100ps

module amo_sequencer
(
    input  wire logic                           clk_i,
    input  wire logic                           reset_i,

    // Requester side.
    input  wire logic                           req_i,
    input  wire logic [amo_pkg::ADDR_WIDTH-1:0] addr_i,
    input  wire amo_pkg::amo_op_e               op_i,
    input  wire logic [amo_pkg::DATA_WIDTH-1:0] wdata_i,
    output var  logic                           ack_o,
    output var  logic [amo_pkg::DATA_WIDTH-1:0] rdata_o,

    // Memory side.
    input  wire logic [amo_pkg::DATA_WIDTH-1:0] mem_rd_data_i,
    output var  logic                           mem_rd_en_o,
    output var  logic                           mem_wr_en_o,
    output var  logic [amo_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    output var  logic [amo_pkg::DATA_WIDTH-1:0] mem_wr_data_o,

    // ALU and reservation side.
    input  wire logic [amo_pkg::DATA_WIDTH-1:0] alu_result_i,
    input  wire logic                           sc_ok_i,
    output var  amo_pkg::amo_op_e               op_q_o,
    output var  logic [amo_pkg::DATA_WIDTH-1:0] operand_q_o,
    output var  logic                           exec_o
);

    // Idle, memory read, compute and write, response held.
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_READ = 2'd1,
        ST_EXEC = 2'd2,
        ST_ACK  = 2'd3
    } seq_state_e;

    seq_state_e                     state_q;
    seq_state_e                     state_d;
    logic [amo_pkg::ADDR_WIDTH-1:0] addr_q;
    amo_pkg::amo_op_e               op_q;
    logic [amo_pkg::DATA_WIDTH-1:0] operand_q;
    logic [amo_pkg::DATA_WIDTH-1:0] rdata_q;
    logic                           accept;
    logic                           do_write;

    // New request seen while idle.
    assign accept = (state_q == ST_IDLE) && req_i;

    always_comb
    begin : next_state_comb
        state_d = state_q;
        case (state_q)
            ST_IDLE:
                if (req_i)
                begin
                    state_d = ST_READ;
                end
            // Read issued here, data registered at the next edge.
            ST_READ:
                state_d = ST_EXEC;
            // Single cycle, so the write happens once.
            ST_EXEC:
                state_d = ST_ACK;
            // Hold the response until the requester lets go.
            ST_ACK:
                if (!req_i)
                begin
                    state_d = ST_IDLE;
                end
            default:
                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin : state_ff
        if (reset_i)
        begin
            state_q <= ST_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Request payload captured on entry to read.
    always_ff @(posedge clk_i)
    begin : req_latch_ff
        if (accept)
        begin
            addr_q    <= addr_i;
            op_q      <= op_i;
            operand_q <= wdata_i;
        end
    end

    // Decide whether the computed word goes back to memory.
    always_comb
    begin : write_decision_comb
        case (op_q)
            amo_pkg::OP_LOAD,
            amo_pkg::OP_LR:
                do_write = 1'b0;
            // Only a live reservation lets SC store.
            amo_pkg::OP_SC:
                do_write = sc_ok_i;
            default:
                do_write = 1'b1;
        endcase
    end

    // Response word, fixed once the operation executes.
    always_ff @(posedge clk_i)
    begin : response_ff
        if (state_q == ST_EXEC)
        begin
            if (op_q == amo_pkg::OP_SC)
            begin
                rdata_q <= sc_ok_i ? '0 : amo_pkg::SC_FAIL_CODE;
            end
            else
            begin
                // Old word for loads and all AMOs.
                rdata_q <= mem_rd_data_i;
            end
        end
    end

    // Memory control follows the state directly.
    assign mem_rd_en_o   = (state_q == ST_READ);
    assign mem_wr_en_o   = (state_q == ST_EXEC) && do_write;
    assign mem_addr_o    = addr_q;
    assign mem_wr_data_o = alu_result_i;

    // Latched request towards ALU and reservation.
    assign op_q_o      = op_q;
    assign operand_q_o = operand_q;
    assign exec_o      = (state_q == ST_EXEC);

    // Requester response.
    assign ack_o   = (state_q == ST_ACK);
    assign rdata_o = rdata_q;

endmodule

/* logic/amo_unit.sv */
// Top level of the AMO unit with sequencer, word memory, ALU and reservation.
`timescale 1ns/100ps

module amo_unit
(
    input  wire logic                           clk_i,
    input  wire logic                           reset_i,
    // Four-phase request.
    input  wire logic                           req_i,
    input  wire logic [amo_pkg::ADDR_WIDTH-1:0] addr_i,
    input  wire amo_pkg::amo_op_e               op_i,
    input  wire logic [amo_pkg::DATA_WIDTH-1:0] wdata_i,
    // Acknowledge with response word.
    output var  logic                           ack_o,
    output var  logic [amo_pkg::DATA_WIDTH-1:0] rdata_o
);

    // Memory port.
    logic                           mem_rd_en;
    logic                           mem_wr_en;
    logic [amo_pkg::ADDR_WIDTH-1:0] mem_addr;
    logic [amo_pkg::DATA_WIDTH-1:0] mem_wr_data;
    logic [amo_pkg::DATA_WIDTH-1:0] mem_rd_data;

    // Latched request and compute path.
    amo_pkg::amo_op_e               op_q;
    logic [amo_pkg::DATA_WIDTH-1:0] operand_q;
    logic [amo_pkg::DATA_WIDTH-1:0] alu_result;

    // Reservation handshake.
    logic                           exec;
    logic                           sc_ok;

    amo_sequencer i_sequencer (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .op_i          (op_i),
        .wdata_i       (wdata_i),
        .ack_o         (ack_o),
        .rdata_o       (rdata_o),
        .mem_rd_data_i (mem_rd_data),
        .mem_rd_en_o   (mem_rd_en),
        .mem_wr_en_o   (mem_wr_en),
        .mem_addr_o    (mem_addr),
        .mem_wr_data_o (mem_wr_data),
        .alu_result_i  (alu_result),
        .sc_ok_i       (sc_ok),
        .op_q_o        (op_q),
        .operand_q_o   (operand_q),
        .exec_o        (exec)
    );

    amo_word_ram i_word_ram (
        .clk_i     (clk_i),
        .rd_en_i   (mem_rd_en),
        .wr_en_i   (mem_wr_en),
        .addr_i    (mem_addr),
        .wr_data_i (mem_wr_data),
        .rd_data_o (mem_rd_data)
    );

    // Old word straight from the memory read register.
    amo_alu i_alu (
        .ld_data_i (mem_rd_data),
        .st_data_i (operand_q),
        .op_i      (op_q),
        .result_o  (alu_result)
    );

    // Tracks the address of the latest LR.
    amo_reservation i_reservation (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .exec_i  (exec),
        .op_i    (op_q),
        .addr_i  (mem_addr),
        .sc_ok_o (sc_ok)
    );

endmodule

/* testbench/amo_unit_model.svh */
// Shadow memory, shadow reservation and response prediction for the AMO unit testbench.

// Shadow copy of the word memory.
logic [amo_pkg::DATA_WIDTH-1:0] shadow_mem [amo_pkg::MEM_DEPTH];
// Word holds a defined value, memory is not reset.
logic [amo_pkg::MEM_DEPTH-1:0]  shadow_known;
logic                           shadow_rsv_valid;
logic [amo_pkg::ADDR_WIDTH-1:0] shadow_rsv_addr;

function automatic void model_reset();
    shadow_known     = '0;
    shadow_rsv_valid = 1'b0;
    shadow_rsv_addr  = '0;
endfunction

// Word that an operation leaves in memory.
function automatic logic [amo_pkg::DATA_WIDTH-1:0] model_new_word(
    input amo_pkg::amo_op_e               op,
    input logic [amo_pkg::DATA_WIDTH-1:0] old_w,
    input logic [amo_pkg::DATA_WIDTH-1:0] opnd
);
    case (op)
        amo_pkg::OP_ADD:  return old_w + opnd;
        amo_pkg::OP_AND:  return old_w & opnd;
        amo_pkg::OP_OR:   return old_w | opnd;
        amo_pkg::OP_XOR:  return old_w ^ opnd;
        amo_pkg::OP_MAX:  return ($signed(opnd) >= $signed(old_w)) ? opnd : old_w;
        amo_pkg::OP_MIN:  return ($signed(opnd) <= $signed(old_w)) ? opnd : old_w;
        amo_pkg::OP_MAXU: return (opnd >= old_w) ? opnd : old_w;
        amo_pkg::OP_MINU: return (opnd <= old_w) ? opnd : old_w;
        // Store, SC and swap take the operand.
        default:          return opnd;
    endcase
endfunction

// Applies one request to the shadow state, returns the expected response.
function automatic logic [amo_pkg::DATA_WIDTH-1:0] predict(
    input  logic [amo_pkg::ADDR_WIDTH-1:0] addr,
    input  amo_pkg::amo_op_e               op,
    input  logic [amo_pkg::DATA_WIDTH-1:0] opnd,
    output logic                           resp_known
);
    logic [amo_pkg::DATA_WIDTH-1:0] resp;
    logic                           writes;
    resp       = shadow_mem[addr];
    resp_known = shadow_known[addr];
    writes     = (op != amo_pkg::OP_LOAD) && (op != amo_pkg::OP_LR);
    // SC succeeds only on a live reservation of this word.
    if (op == amo_pkg::OP_SC)
    begin
        writes     = shadow_rsv_valid && (shadow_rsv_addr == addr);
        resp       = writes ? '0 : amo_pkg::SC_FAIL_CODE;
        resp_known = 1'b1;
    end
    if (op == amo_pkg::OP_LR)
    begin
        shadow_rsv_valid = 1'b1;
        shadow_rsv_addr  = addr;
    end
    else if ((op == amo_pkg::OP_SC) || (writes && (shadow_rsv_addr == addr)))
    begin
        shadow_rsv_valid = 1'b0;
    end
    if (writes)
    begin
        shadow_mem[addr] = model_new_word(op, shadow_mem[addr], opnd);
        // Operand-only results are defined even over an unknown word.
        shadow_known[addr] = shadow_known[addr] || (op == amo_pkg::OP_STORE) ||
                             (op == amo_pkg::OP_SWAP) || (op == amo_pkg::OP_SC);
    end
    return resp;
endfunction

/* testbench/amo_unit_tb.sv */
// Testbench for the AMO unit with stimulus tasks, protocol and value assertions, timeout.
`timescale 1ns/100ps

module amo_unit_tb;

    // Budget of about 300 transactions at about 8 cycles, doubled, plus slack.
    localparam int unsigned TXN_BUDGET  = 300;
    localparam int unsigned TXN_CYCLES  = 8;
    localparam int unsigned MAX_CYCLES  = TXN_BUDGET * TXN_CYCLES * 2 + 200;

    logic                           clk_i;
    logic                           reset_i;
    logic                           req_i;
    logic [amo_pkg::ADDR_WIDTH-1:0] addr_i;
    amo_pkg::amo_op_e               op_i;
    logic [amo_pkg::DATA_WIDTH-1:0] wdata_i;
    logic                           ack_o;
    logic [amo_pkg::DATA_WIDTH-1:0] rdata_o;

    // Expected response of the request in flight.
    logic [amo_pkg::DATA_WIDTH-1:0] exp_rdata;
    logic                           exp_known;

    int unsigned error_count;
    int unsigned test_count;
    int unsigned txn_count;
    int unsigned cycle_count;

    `include "amo_unit_model.svh"

    amo_unit dut (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (req_i),
        .addr_i  (addr_i),
        .op_i    (op_i),
        .wdata_i (wdata_i),
        .ack_o   (ack_o),
        .rdata_o (rdata_o)
    );

    initial
    begin : clock_gen
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // No ack straight out of reset.
    ack_after_reset_a: assert property (@(posedge clk_i) reset_i |=> !ack_o)
    else
    begin
        $display("ack_o was high right after reset");
        error_count++;
    end

    // Ack three edges after the request is first seen.
    ack_latency_a: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(req_i) |-> !ack_o ##1 !ack_o ##1 !ack_o ##1 ack_o)
    else
    begin
        $display("ack_o did not rise exactly 3 cycles after req_i");
        error_count++;
    end

    // Back-pressure keeps the response steady.
    ack_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_o && req_i |=> ack_o && $stable(rdata_o))
    else
    begin
        $display("ack_o or rdata_o changed while req_i was held high");
        error_count++;
    end

    ack_fall_a: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_o && !req_i |=> !ack_o)
    else
    begin
        $display("ack_o did not fall on the edge after req_i dropped");
        error_count++;
    end

    idle_quiet_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !req_i && !ack_o |=> !ack_o)
    else
    begin
        $display("ack_o rose without a request");
        error_count++;
    end

    // Response word against the model.
    rdata_value_a: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_o) && exp_known |-> rdata_o == exp_rdata)
    else
    begin
        $display("mismatch rdata_o: expected 0x%h, got 0x%h", exp_rdata, rdata_o);
        error_count++;
    end

    always @(posedge clk_i)
    begin : cycle_counter
        cycle_count <= cycle_count + 1;
    end

    initial
    begin : timeout_watch
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [amo_pkg::DATA_WIDTH-1:0] rand_word();
        return {$urandom(), $urandom()};
    endfunction

    // One four-phase transaction, called and left on a falling edge.
    task automatic run_txn(
        input int unsigned                    addr,
        input amo_pkg::amo_op_e               op,
        input logic [amo_pkg::DATA_WIDTH-1:0] wdata,
        input int unsigned                    hold
    );
        logic [amo_pkg::ADDR_WIDTH-1:0] a;
        a         = addr[amo_pkg::ADDR_WIDTH-1:0];
        exp_rdata = predict(a, op, wdata, exp_known);
        addr_i    = a;
        op_i      = op;
        wdata_i   = wdata;
        req_i     = 1'b1;
        do
            @(negedge clk_i);
        while (!ack_o);
        // Extra cycles of back-pressure.
        repeat (hold) @(negedge clk_i);
        req_i = 1'b0;
        do
            @(negedge clk_i);
        while (ack_o);
        txn_count++;
    endtask

    task automatic finish_test(input string name, input int unsigned errors_before);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    endtask

    // Fills every word with random holds, then loads under back-pressure.
    task automatic check_handshake();
        for (int i = 0; i < amo_pkg::MEM_DEPTH; i++)
        begin
            run_txn(i, amo_pkg::OP_STORE, rand_word(), $urandom_range(0, 6));
            // Idle cycles with req_i low between requests.
            repeat ($urandom_range(1, 3)) @(negedge clk_i);
        end
        for (int i = 0; i < 4; i++)
        begin
            run_txn($urandom_range(0, 15), amo_pkg::OP_LOAD, '0, $urandom_range(1, 8));
        end
    endtask

    task automatic check_store_load();
        for (int i = 0; i < amo_pkg::MEM_DEPTH; i++)
        begin
            run_txn(i, amo_pkg::OP_STORE, rand_word(), 0);
        end
        for (int i = 0; i < amo_pkg::MEM_DEPTH; i++)
        begin
            run_txn(i, amo_pkg::OP_LOAD, rand_word(), 0);
        end
    endtask

    task automatic check_rmw_ops();
        amo_pkg::amo_op_e ops [5];
        int unsigned      addr;
        ops = '{amo_pkg::OP_SWAP, amo_pkg::OP_ADD, amo_pkg::OP_AND,
                amo_pkg::OP_OR, amo_pkg::OP_XOR};
        for (int i = 0; i < 40; i++)
        begin
            addr = $urandom_range(0, 15);
            run_txn(addr, ops[$urandom_range(0, 4)], rand_word(), 0);
            // Follow-up load shows the written word.
            run_txn(addr, amo_pkg::OP_LOAD, '0, 0);
        end
    endtask

    task automatic check_min_max();
        amo_pkg::amo_op_e               ops [4];
        logic [amo_pkg::DATA_WIDTH-1:0] bounds [5];
        int unsigned                    addr;
        ops = '{amo_pkg::OP_MAX, amo_pkg::OP_MAXU, amo_pkg::OP_MIN, amo_pkg::OP_MINU};
        // Zero, one, minus one, largest positive, most negative.
        bounds[0] = '0;
        bounds[1] = 1;
        bounds[2] = '1;
        bounds[3] = {1'b0, {(amo_pkg::DATA_WIDTH - 1){1'b1}}};
        bounds[4] = {1'b1, {(amo_pkg::DATA_WIDTH - 1){1'b0}}};
        for (int k = 0; k < 4; k++)
        begin
            for (int i = 0; i < 5; i++)
            begin
                addr = i + k;
                run_txn(addr, amo_pkg::OP_STORE, bounds[i], 0);
                run_txn(addr, ops[k], bounds[(i + 2) % 5], 0);
                run_txn(addr, amo_pkg::OP_LOAD, '0, 0);
            end
        end
        // Random values on top.
        for (int i = 0; i < 8; i++)
        begin
            addr = $urandom_range(0, 15);
            run_txn(addr, ops[$urandom_range(0, 3)], rand_word(), 0);
            run_txn(addr, amo_pkg::OP_LOAD, '0, 0);
        end
    endtask

    task automatic check_lr_sc_basic();
        run_txn(3, amo_pkg::OP_LR, '0, 0);
        run_txn(3, amo_pkg::OP_SC, rand_word(), 0);
        run_txn(3, amo_pkg::OP_LOAD, '0, 0);
        // Reservation consumed, second SC fails.
        run_txn(3, amo_pkg::OP_SC, rand_word(), 0);
        run_txn(5, amo_pkg::OP_SC, rand_word(), 0);
        run_txn(5, amo_pkg::OP_LOAD, '0, 0);
        // Reservation held on another word.
        run_txn(11, amo_pkg::OP_LR, '0, 0);
        run_txn(12, amo_pkg::OP_SC, rand_word(), 0);
        run_txn(12, amo_pkg::OP_LOAD, '0, 0);
    endtask

    task automatic check_lr_sc_conflict();
        run_txn(7, amo_pkg::OP_LR, '0, 0);
        run_txn(7, amo_pkg::OP_STORE, rand_word(), 0);
        run_txn(7, amo_pkg::OP_SC, rand_word(), 0);
        run_txn(7, amo_pkg::OP_LOAD, '0, 0);
        // Store elsewhere keeps the reservation.
        run_txn(9, amo_pkg::OP_LR, '0, 0);
        run_txn(10, amo_pkg::OP_STORE, rand_word(), 0);
        run_txn(9, amo_pkg::OP_SC, rand_word(), 0);
        run_txn(9, amo_pkg::OP_LOAD, '0, 0);
        // Held ADD must add once.
        run_txn(2, amo_pkg::OP_ADD, rand_word(), $urandom_range(4, 10));
        run_txn(2, amo_pkg::OP_LOAD, '0, 0);
    endtask

    initial
    begin : main_seq
        int unsigned mark;
        void'($urandom(18470));
        reset_i     = 1'b1;
        req_i       = 1'b0;
        addr_i      = '0;
        op_i        = amo_pkg::OP_LOAD;
        wdata_i     = '0;
        exp_rdata   = '0;
        exp_known   = 1'b0;
        error_count = 0;
        test_count  = 0;
        txn_count   = 0;
        cycle_count = 0;
        model_reset();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        mark = error_count;
        check_handshake();
        finish_test("reset and handshake", mark);
        mark = error_count;
        check_store_load();
        finish_test("store and load", mark);
        mark = error_count;
        check_rmw_ops();
        finish_test("arithmetic and logical amo", mark);
        mark = error_count;
        check_min_max();
        finish_test("min and max", mark);
        mark = error_count;
        check_lr_sc_basic();
        finish_test("lr/sc basic", mark);
        mark = error_count;
        check_lr_sc_conflict();
        finish_test("lr/sc conflict and back-pressure", mark);

        $display("%0d tests, %0d transactions, %0d errors", test_count, txn_count, error_count);
        if (error_count == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
logic/amo_pkg.sv
logic/amo_alu.sv
logic/amo_reservation.sv
logic/amo_word_ram.sv
logic/amo_sequencer.sv
logic/amo_unit.sv
testbench/amo_unit_tb.sv

/* Bender.yml */
package:
  name: amo_unit

sources:
  # Package first, then leaf blocks, then the top level.
  - logic/amo_pkg.sv
  - logic/amo_alu.sv
  - logic/amo_reservation.sv
  - logic/amo_word_ram.sv
  - logic/amo_sequencer.sv
  - logic/amo_unit.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/amo_unit_tb.sv
